//--- Makefile
# Verilator build and run for the aluCore testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module aluCoreTb \
		-f sim.f -Mdir obj_dir -o aluCoreSim

run: compile
	./obj_dir/aluCoreSim | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim.f
verilog/aluPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/statusReg.sv
verilog/executeStage.sv
verilog/aluCore.sv
tests/aluCore_chk.sv
tests/aluCoreTb.sv

//--- tests/aluCoreTb.sv
`timescale 1ns/100ps

module aluCoreTb import aluPkg::*;
();

	logic clk = 1'b0;
	logic rst;
	logic instValid;
	logic instReady;
	aluOp opcode;
	logic [3:0] rDest;
	logic [3:0] rSrc;
	logic [7:0] imm;
	logic resValid;
	logic resReady;
	logic [15:0] resData;
	logic resCarry;
	logic resFlag;
	logic resLow;
	logic resNegative;
	logic resZero;

	integer seed = 32'h1a46_08d1;
	int errors = 0;
	int checks = 0;
	int sentCount = 0;
	int cycleNo = 0;
	int wdCycles;
	int assertFails;

	// Model state and queued work as {opcode, rDest, rSrc, imm}
	logic [15:0] mregs [16];
	logic [4:0] mflags;
	logic [23:0] instQ [$];
	logic [20:0] expQ [$];
	int acceptQ [$];

	aluCore #(.dataWidth(16), .regCount(16)) dut0 (
		.clk(clk), .rst(rst), .instValid(instValid), .instReady(instReady),
		.opcode(opcode), .rDest(rDest), .rSrc(rSrc), .imm(imm),
		.resValid(resValid), .resReady(resReady), .resData(resData),
		.resCarry(resCarry), .resFlag(resFlag), .resLow(resLow),
		.resNegative(resNegative), .resZero(resZero)
	);

	bind executeStage aluCoreChk chk0 (
		.clk(clk), .rst(rst), .instValid(instValid), .instReady(instReady),
		.resValid(resValid), .resReady(resReady), .resData(resData),
		.resCarry(resCarry), .resFlag(resFlag), .resLow(resLow),
		.resNegative(resNegative), .resZero(resZero)
	);

	always #5 clk = ~clk;

	// Twenty cycles per instruction plus room for reset
	initial
	begin
		wdCycles = 0;
		while (wdCycles <= sentCount * 20 + 500)
		begin
			@(posedge clk);
			wdCycles++;
		end
		$display("Watchdog: run timed out after %0d cycles", wdCycles);
		$display("Simulation failed");
		$finish;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Returns {c, carry, flag, low, negative, zero}
	function automatic logic [20:0] expectAlu(input aluOp op, input logic [15:0] a,
		input logic [15:0] b, input logic cin);
		logic [16:0] sum;
		logic [15:0] c;
		logic cy;
		logic ov;
		logic lo;
		logic ng;
		logic z;
		int sa;
		int sb;
		sa = int'($signed(a));
		sb = int'($signed(b));
		c = 16'd0;
		sum = 17'd0;
		{cy, ov, lo, ng, z} = 5'b0;
		case (op)
			ADD, ADDI:
			begin
				c = a + b;
				ov = (sa + sb > 32767) || (sa + sb < -32768);
				z = (c == 16'd0);
			end
			ADDU, ADDUI, ADDCU, ADDCUI:
			begin
				sum = {1'b0, a} + {1'b0, b};
				if (op == ADDCU || op == ADDCUI)
					sum = sum + 17'(cin);
				{cy, c} = sum;
				z = (c == 16'd0);
			end
			SUBI:
			begin
				c = a - b;
				ov = (sa - sb > 32767) || (sa - sb < -32768);
				z = (c == 16'd0);
			end
			CMP, CMPI, AND, OR, XOR, NOT:
			begin
				if (op == AND)
					c = a & b;
				else if (op == OR)
					c = a | b;
				else if (op == XOR)
					c = a ^ b;
				else if (op == NOT)
					c = ~a;
				// Flags compare the operands rather than the result
				lo = (a < b);
				ng = (sa < sb);
				z = (a == b);
			end
			LSH, LSHI, ALSH, RSH, RSHI, ARSH:
			begin
				if (op == RSH || op == RSHI)
					c = a >> b[3:0];
				else if (op == ARSH)
					c = 16'(sa >>> b[3:0]);
				else
					c = a << b[3:0];
				z = (c == 16'd0);
			end
			default:
				c = 16'd0;
		endcase
		return {c, cy, ov, lo, ng, z};
	endfunction

	task automatic predict(input aluOp op, input logic [3:0] d, input logic [3:0] s,
		input logic [7:0] i, output logic [20:0] e);
		logic [15:0] b;
		logic [20:0] r;
		logic known;
		b = (op inside {ADDI, ADDUI, ADDCUI, SUBI, CMPI, LSHI, RSHI}) ?
			{{8{i[7]}}, i} : mregs[s];
		r = expectAlu(op, mregs[d], b, mflags[4]);
		known = op inside {ADD, ADDU, ADDI, ADDUI, ADDCU, ADDCUI, SUBI, CMP, CMPI,
			AND, OR, XOR, NOT, LSH, LSHI, RSH, RSHI, ALSH, ARSH};
		// NOP and unknown codes report the held flags
		e = known ? r : {r[20:5], mflags};
		if (known && !(op inside {CMP, CMPI}))
			mregs[d] = r[20:5];
		if (known)
			mflags = r[4:0];
	endtask

	task automatic queueInst(input aluOp op, input logic [3:0] d, input logic [3:0] s,
		input logic [7:0] i);
		logic [20:0] e;
		predict(op, d, s, i, e);
		instQ.push_back({op, d, s, i});
		expQ.push_back(e);
		sentCount++;
	endtask

	//////////////////////////////
	// Cycle engine
	//////////////////////////////

	// Starts and ends 1 ns after a rising edge
	task automatic runQueued(input bit randomReady, input bit strict);
		logic [20:0] e;
		int acc;
		while (instQ.size() > 0 || expQ.size() > 0)
		begin
			instValid = (instQ.size() > 0);
			if (instValid)
			begin
				opcode = aluOp'(instQ[0][23:16]);
				rDest = instQ[0][15:12];
				rSrc = instQ[0][11:8];
				imm = instQ[0][7:0];
			end
			resReady = randomReady ? 1'($random(seed)) : 1'b1;
			@(negedge clk);
			if (strict && instValid)
				checkValue("instReady", 32'(instReady), 32'd1);
			if (resValid && resReady)
			begin
				if (expQ.size() == 0)
				begin
					errors++;
					$display("Result at %0t arrived with no instruction outstanding", $time);
				end
				else
				begin
					e = expQ.pop_front();
					acc = acceptQ.pop_front();
					checkValue("resData", 32'(resData), 32'(e[20:5]));
					checkValue("resCarry", 32'(resCarry), 32'(e[4]));
					checkValue("resFlag", 32'(resFlag), 32'(e[3]));
					checkValue("resLow", 32'(resLow), 32'(e[2]));
					checkValue("resNegative", 32'(resNegative), 32'(e[1]));
					checkValue("resZero", 32'(resZero), 32'(e[0]));
					if (strict)
						checkValue("latency", 32'(cycleNo - acc), 32'd1);
				end
			end
			if (instValid && instReady)
			begin
				void'(instQ.pop_front());
				acceptQ.push_back(cycleNo);
			end
			@(posedge clk);
			#1;
			cycleNo++;
		end
		instValid = 1'b0;
		resReady = 1'b1;
		// Nothing extra may follow the last result
		@(negedge clk);
		checkValue("resValid idle", 32'(resValid), 32'd0);
		@(posedge clk);
		#1;
		cycleNo++;
	endtask

	task automatic reportTest(input string name, input int startErrors);
		$display("Test %-12s finished with %0d errors", name, errors - startErrors);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic testReset();
		int startErrors;
		startErrors = errors;
		@(negedge clk);
		checkValue("resValid", 32'(resValid), 32'd0);
		checkValue("instReady", 32'(instReady), 32'd1);
		@(posedge clk);
		#1;
		queueInst(ADD, 1, 2, 8'h00);
		runQueued(1'b0, 1'b0);
		reportTest("reset", startErrors);
	endtask

	task automatic testArith();
		int startErrors;
		startErrors = errors;
		// 0x7F00 doubled overflows into the sign bit
		queueInst(ADDI, 2, 0, 8'h7F);
		queueInst(LSHI, 2, 0, 8'h08);
		queueInst(ADD, 2, 2, 8'h00);
		queueInst(ADDI, 3, 0, 8'hFF);
		queueInst(ADDI, 4, 0, 8'h01);
		queueInst(ADDU, 3, 4, 8'h00);
		queueInst(ADDCU, 4, 4, 8'h00);
		queueInst(ADDI, 6, 0, 8'h01);
		queueInst(LSHI, 6, 0, 8'h0F);
		queueInst(SUBI, 6, 0, 8'h01);
		queueInst(SUBI, 4, 0, 8'h02);
		queueInst(SUBI, 7, 0, 8'h80);
		runQueued(1'b0, 1'b0);
		reportTest("arithmetic", startErrors);
	endtask

	task automatic testCompare();
		int startErrors;
		startErrors = errors;
		queueInst(ADDI, 8, 0, 8'hFF);
		queueInst(ADDI, 9, 0, 8'h01);
		queueInst(CMP, 8, 9, 8'h00);
		queueInst(CMP, 9, 8, 8'h00);
		queueInst(ADDI, 8, 0, 8'h00);
		// Zero stays set through the NOP and the unknown code
		queueInst(CMPI, 9, 0, 8'h01);
		queueInst(NOP, 0, 0, 8'h00);
		queueInst(aluOp'(8'hFF), 1, 2, 8'h33);
		runQueued(1'b0, 1'b0);
		reportTest("compare", startErrors);
	endtask

	task automatic testLogicShift();
		int startErrors;
		startErrors = errors;
		queueInst(ADDI, 10, 0, 8'hF0);
		queueInst(ADDI, 11, 0, 8'h3C);
		queueInst(AND, 10, 11, 8'h00);
		queueInst(OR, 11, 10, 8'h00);
		queueInst(XOR, 10, 11, 8'h00);
		queueInst(NOT, 11, 10, 8'h00);
		queueInst(ADDI, 12, 0, 8'h81);
		queueInst(ADDI, 13, 0, 8'h81);
		queueInst(ADDI, 15, 0, 8'h81);
		// 19 shifts by 3
		queueInst(ADDI, 14, 0, 8'h13);
		queueInst(ARSH, 12, 14, 8'h00);
		queueInst(ALSH, 13, 14, 8'h00);
		queueInst(RSH, 15, 14, 8'h00);
		queueInst(LSH, 12, 14, 8'h00);
		queueInst(LSHI, 13, 0, 8'h14);
		queueInst(RSHI, 15, 0, 8'h2F);
		runQueued(1'b0, 1'b0);
		reportTest("logicShift", startErrors);
	endtask

	task automatic testBackPressure();
		int startErrors;
		startErrors = errors;
		for (int k = 0; k < 30; k++)
		begin
			queueInst(ADDI, 5, 0, 8'($random(seed)));
			queueInst(ADD, 6, 5, 8'h00);
		end
		runQueued(1'b1, 1'b0);
		reportTest("backPressure", startErrors);
	endtask

	task automatic testThroughput();
		int startErrors;
		startErrors = errors;
		for (int k = 0; k < 8; k++)
		begin
			queueInst(ADDUI, 7, 0, 8'(k + 1));
			queueInst(ADD, 7, 7, 8'h00);
		end
		runQueued(1'b0, 1'b1);
		reportTest("throughput", startErrors);
	endtask

	initial
	begin
		rst = 1'b1;
		instValid = 1'b0;
		opcode = NOP;
		rDest = 4'd0;
		rSrc = 4'd0;
		imm = 8'd0;
		resReady = 1'b1;
		mflags = 5'b0;
		for (int r = 0; r < 16; r++)
			mregs[r] = 16'd0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		testReset();
		testArith();
		testCompare();
		testLogicShift();
		testBackPressure();
		testThroughput();

		assertFails = dut0.executeStage0.chk0.failCount;
		$display("Done: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, assertFails);
		if (errors == 0 && assertFails == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tests/aluCore_chk.sv
`timescale 1ns/100ps

module aluCoreChk import aluPkg::*;
#(
	parameter int dataWidth = defDataWidth
)
(
	input logic                 clk,
	input logic                 rst,
	input logic                 instValid,
	input logic                 instReady,
	input logic                 resValid,
	input logic                 resReady,
	input logic [dataWidth-1:0] resData,
	input logic                 resCarry,
	input logic                 resFlag,
	input logic                 resLow,
	input logic                 resNegative,
	input logic                 resZero
);

	// Read back by the testbench at the end of the run
	int failCount = 0;

	// Results accepted and not yet taken
	logic [1:0] pending;

	always_ff @(posedge clk)
	begin
		if (rst)
			pending <= 2'd0;
		else
			pending <= pending + 2'(instValid && instReady) - 2'(resValid && resReady);
	end

	//////////////////////////////
	// Handshake properties
	//////////////////////////////

	// Output register empty after reset
	resetEmpty: assert property (@(posedge clk) rst |=> !resValid)
	else
	begin
		failCount++;
		$error("resValid high in the cycle after reset");
	end

	// Held result must not change under back-pressure
	holdStable: assert property (@(posedge clk) disable iff (rst)
		(resValid && !resReady) |=> resValid && $stable(resData) && $stable(resCarry)
			&& $stable(resFlag) && $stable(resLow) && $stable(resNegative)
			&& $stable(resZero))
	else
	begin
		failCount++;
		$error("result changed while stalled");
	end

	// Ready follows the occupancy counted from both handshakes
	readyRule: assert property (@(posedge clk) disable iff (rst)
		instReady == (pending == 2'd0 || resReady))
	else
	begin
		failCount++;
		$error("instReady does not follow the output register state");
	end

endmodule

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu import aluPkg::*;
#(
	parameter int dataWidth = defDataWidth
)
(
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  aluOp                 opcode,
	input  logic                 carryIn,
	output logic [dataWidth-1:0] c,
	output logic                 carry,
	output logic                 flag,
	output logic                 low,
	output logic                 negative,
	output logic                 zero
);

	localparam int msb = dataWidth - 1;
	localparam int shiftWidth = $clog2(dataWidth);

	// Only the low bits of B select the shift distance
	logic [shiftWidth-1:0] shamt;

	// Comparisons shared by compares and logic ops
	logic ltUnsigned;
	logic ltSigned;
	logic equal;

	assign shamt = b[shiftWidth-1:0];
	assign ltUnsigned = (a < b);
	assign ltSigned = ($signed(a) < $signed(b));
	assign equal = (a == b);

	always_comb
	begin
		// Unnamed flags stay clear
		c = '0;
		carry = 1'b0;
		flag = 1'b0;
		low = 1'b0;
		negative = 1'b0;
		zero = 1'b0;

		case (opcode)
			//////////////////////////////
			// Arithmetic
			//////////////////////////////
			ADD, ADDI:
			begin
				c = a + b;
				// Same operand signs, different result sign
				flag = (~a[msb] & ~b[msb] & c[msb]) | (a[msb] & b[msb] & ~c[msb]);
				zero = (c == '0);
			end

			ADDU, ADDUI:
			begin
				{carry, c} = {1'b0, a} + {1'b0, b};
				zero = (c == '0);
			end

			ADDCU, ADDCUI:
			begin
				{carry, c} = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, carryIn};
				zero = (c == '0);
			end

			SUBI:
			begin
				c = a - b;
				// Operands differ in sign and result leaves the sign of A
				flag = (a[msb] != b[msb]) && (c[msb] != a[msb]);
				zero = (c == '0);
			end

			CMP, CMPI:
			begin
				low = ltUnsigned;
				negative = ltSigned;
				zero = equal;
			end

			//////////////////////////////
			// Logic
			//////////////////////////////
			// Flags here compare A with B rather than look at C
			AND:
			begin
				c = a & b;
				low = ltUnsigned;
				negative = ltSigned;
				zero = equal;
			end

			OR:
			begin
				c = a | b;
				low = ltUnsigned;
				negative = ltSigned;
				zero = equal;
			end

			XOR:
			begin
				c = a ^ b;
				low = ltUnsigned;
				negative = ltSigned;
				zero = equal;
			end

			NOT:
			begin
				c = ~a;
				low = ltUnsigned;
				negative = ltSigned;
				zero = equal;
			end

			//////////////////////////////
			// Shifts
			//////////////////////////////
			LSH, LSHI:
			begin
				c = a << shamt;
				zero = (c == '0);
			end

			// Same as a logical left shift
			ALSH:
			begin
				c = a <<< shamt;
				zero = (c == '0);
			end

			RSH, RSHI:
			begin
				c = a >> shamt;
				zero = (c == '0);
			end

			ARSH:
			begin
				c = $signed(a) >>> shamt;
				zero = (c == '0);
			end

			// NOP and unknown codes give all zeros
			default:
			begin
				c = '0;
			end
		endcase
	end

endmodule

//--- verilog/aluCore.sv
`timescale 1ns/100ps

module aluCore import aluPkg::*;
#(
	parameter int dataWidth = defDataWidth,
	parameter int regCount = defRegCount,
	localparam int addrWidth = $clog2(regCount)
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 instValid,
	output logic                 instReady,
	input  aluOp                 opcode,
	input  logic [addrWidth-1:0] rDest,
	input  logic [addrWidth-1:0] rSrc,
	input  logic [immWidth-1:0]  imm,
	output logic                 resValid,
	input  logic                 resReady,
	output logic [dataWidth-1:0] resData,
	output logic                 resCarry,
	output logic                 resFlag,
	output logic                 resLow,
	output logic                 resNegative,
	output logic                 resZero
);

	logic [addrWidth-1:0] rdAddrA;
	logic [addrWidth-1:0] rdAddrB;
	logic [dataWidth-1:0] rdDataA;
	logic [dataWidth-1:0] rdDataB;
	logic                 wrEn;
	logic [addrWidth-1:0] wrAddr;
	logic [dataWidth-1:0] wrData;

	logic [dataWidth-1:0] aluA;
	logic [dataWidth-1:0] aluB;
	aluOp                 aluOpcode;
	logic [dataWidth-1:0] aluC;
	logic                 aluCarry;
	logic                 aluFlag;
	logic                 aluLow;
	logic                 aluNegative;
	logic                 aluZero;

	logic                 flagWrEn;
	logic                 stCarry;
	logic                 stFlag;
	logic                 stLow;
	logic                 stNegative;
	logic                 stZero;

	regFile #(.dataWidth(dataWidth), .regCount(regCount)) regFile0 (
		.clk(clk), .rst(rst), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	statusReg statusReg0 (
		.clk(clk), .rst(rst), .flagWrEn(flagWrEn),
		.carry(aluCarry), .flag(aluFlag), .low(aluLow),
		.negative(aluNegative), .zero(aluZero),
		.carryOut(stCarry), .flagOut(stFlag), .lowOut(stLow),
		.negativeOut(stNegative), .zeroOut(stZero)
	);

	// Stored Carry closes the loop for carry-chained adds
	alu #(.dataWidth(dataWidth)) alu0 (
		.a(aluA), .b(aluB), .opcode(aluOpcode), .carryIn(stCarry),
		.c(aluC), .carry(aluCarry), .flag(aluFlag), .low(aluLow),
		.negative(aluNegative), .zero(aluZero)
	);

	executeStage #(.dataWidth(dataWidth), .regCount(regCount)) executeStage0 (
		.clk(clk), .rst(rst),
		.instValid(instValid), .instReady(instReady), .opcode(opcode),
		.rDest(rDest), .rSrc(rSrc), .imm(imm),
		.resValid(resValid), .resReady(resReady), .resData(resData),
		.resCarry(resCarry), .resFlag(resFlag), .resLow(resLow),
		.resNegative(resNegative), .resZero(resZero),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.aluA(aluA), .aluB(aluB), .aluOpcode(aluOpcode), .aluC(aluC),
		.aluCarry(aluCarry), .aluFlag(aluFlag), .aluLow(aluLow),
		.aluNegative(aluNegative), .aluZero(aluZero),
		.flagWrEn(flagWrEn),
		.stCarry(stCarry), .stFlag(stFlag), .stLow(stLow),
		.stNegative(stNegative), .stZero(stZero)
	);

endmodule

//--- verilog/aluPkg.sv
package aluPkg;

	// Datapath defaults overridden from the top level
	parameter int defDataWidth = 16;
	parameter int defRegCount = 16;

	// Immediate field is always one byte
	parameter int immWidth = 8;

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	typedef enum logic [7:0] {
		// Register and immediate adds
		ADD    = 8'h05,
		ADDU   = 8'h06,
		ADDI   = 8'h50,
		ADDUI  = 8'h60,
		ADDCU  = 8'h07,
		ADDCUI = 8'h70,
		SUBI   = 8'h90,
		// Compares
		CMP    = 8'h0B,
		CMPI   = 8'hB0,
		// Bitwise logic
		AND    = 8'h01,
		OR     = 8'h02,
		XOR    = 8'h03,
		NOT    = 8'h04,
		// Shifts
		LSH    = 8'h84,
		LSHI   = 8'h80,
		RSH    = 8'h8C,
		RSHI   = 8'h88,
		ALSH   = 8'h86,
		ARSH   = 8'h8E,
		NOP    = 8'h00
	} aluOp;

endpackage

//--- verilog/executeStage.sv
`timescale 1ns/100ps

module executeStage import aluPkg::*;
#(
	parameter int dataWidth = defDataWidth,
	parameter int regCount = defRegCount,
	localparam int addrWidth = $clog2(regCount)
)
(
	input  logic                 clk,
	input  logic                 rst,
	// Instruction handshake
	input  logic                 instValid,
	output logic                 instReady,
	input  aluOp                 opcode,
	input  logic [addrWidth-1:0] rDest,
	input  logic [addrWidth-1:0] rSrc,
	input  logic [immWidth-1:0]  imm,
	// Result handshake
	output logic                 resValid,
	input  logic                 resReady,
	output logic [dataWidth-1:0] resData,
	output logic                 resCarry,
	output logic                 resFlag,
	output logic                 resLow,
	output logic                 resNegative,
	output logic                 resZero,
	// Register file
	output logic [addrWidth-1:0] rdAddrA,
	output logic [addrWidth-1:0] rdAddrB,
	input  logic [dataWidth-1:0] rdDataA,
	input  logic [dataWidth-1:0] rdDataB,
	output logic                 wrEn,
	output logic [addrWidth-1:0] wrAddr,
	output logic [dataWidth-1:0] wrData,
	// ALU
	output logic [dataWidth-1:0] aluA,
	output logic [dataWidth-1:0] aluB,
	output aluOp                 aluOpcode,
	input  logic [dataWidth-1:0] aluC,
	input  logic                 aluCarry,
	input  logic                 aluFlag,
	input  logic                 aluLow,
	input  logic                 aluNegative,
	input  logic                 aluZero,
	// Status register
	output logic                 flagWrEn,
	input  logic                 stCarry,
	input  logic                 stFlag,
	input  logic                 stLow,
	input  logic                 stNegative,
	input  logic                 stZero
);

	logic accept;
	logic isImm;
	logic writesReg;
	logic setsFlags;
	logic [dataWidth-1:0] immExt;

	// Opcode classes
	always_comb
	begin
		isImm = 1'b0;
		writesReg = 1'b1;
		setsFlags = 1'b1;
		case (opcode)
			ADDI, ADDUI, ADDCUI, SUBI, LSHI, RSHI:
				isImm = 1'b1;
			CMPI:
			begin
				isImm = 1'b1;
				writesReg = 1'b0;
			end
			CMP:
				writesReg = 1'b0;
			ADD, ADDU, ADDCU, AND, OR, XOR, NOT, LSH, RSH, ALSH, ARSH:
				isImm = 1'b0;
			// NOP and unknown codes touch nothing
			default:
			begin
				writesReg = 1'b0;
				setsFlags = 1'b0;
			end
		endcase
	end

	//////////////////////////////
	// Operands and write-back
	//////////////////////////////

	assign immExt = {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};

	assign rdAddrA = rDest;
	assign rdAddrB = rSrc;
	assign aluA = rdDataA;
	assign aluB = isImm ? immExt : rdDataB;
	assign aluOpcode = opcode;

	// Room when empty or draining this cycle
	assign instReady = !resValid || resReady;
	assign accept = instValid && instReady;

	assign wrEn = accept && writesReg;
	assign wrAddr = rDest;
	assign wrData = aluC;
	assign flagWrEn = accept && setsFlags;

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			resValid <= 1'b0;
		else if (accept)
			resValid <= 1'b1;
		else if (resReady)
			resValid <= 1'b0;
	end

	// Ops without a flag update report the held status
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			resData <= aluC;
			resCarry <= setsFlags ? aluCarry : stCarry;
			resFlag <= setsFlags ? aluFlag : stFlag;
			resLow <= setsFlags ? aluLow : stLow;
			resNegative <= setsFlags ? aluNegative : stNegative;
			resZero <= setsFlags ? aluZero : stZero;
		end
	end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/100ps

module regFile import aluPkg::*;
#(
	parameter int dataWidth = defDataWidth,
	parameter int regCount = defRegCount,
	localparam int addrWidth = $clog2(regCount)
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [addrWidth-1:0] rdAddrA,
	input  logic [addrWidth-1:0] rdAddrB,
	input  logic                 wrEn,
	input  logic [addrWidth-1:0] wrAddr,
	input  logic [dataWidth-1:0] wrData,
	output logic [dataWidth-1:0] rdDataA,
	output logic [dataWidth-1:0] rdDataB
);

	logic [dataWidth-1:0] regs [regCount];

	// Asynchronous reads in the same cycle as the address
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	// Every register starts from zero so ADDI can load it
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn)
		begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

//--- verilog/statusReg.sv
`timescale 1ns/100ps

module statusReg
(
	input  logic clk,
	input  logic rst,
	input  logic flagWrEn,
	input  logic carry,
	input  logic flag,
	input  logic low,
	input  logic negative,
	input  logic zero,
	output logic carryOut,
	output logic flagOut,
	output logic lowOut,
	output logic negativeOut,
	output logic zeroOut
);

	//////////////////////////////
	// Program status flags
	//////////////////////////////

	// All five load together from the ALU
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			carryOut <= 1'b0;
			flagOut <= 1'b0;
			lowOut <= 1'b0;
			negativeOut <= 1'b0;
			zeroOut <= 1'b0;
		end
		else if (flagWrEn)
		begin
			carryOut <= carry;
			flagOut <= flag;
			lowOut <= low;
			negativeOut <= negative;
			zeroOut <= zero;
		end
	end

	// carryOut also feeds the ALU for ADDCU and ADDCUI

endmodule
